//--- project.f
+incdir+verif
common/cpu_ctl_pkg.sv
hdl/opcode_decode.sv
sequencer/ctl_fsm.sv
sequencer/ctl_microcode.sv
hdl/ab_mode_map.sv
hdl/ctl_top.sv
verif/ctl_tb.sv

//--- verif/ctl_tb_table.svh
// Instruction table for the control sequencer testbench, one row per instruction
`ifndef CTL_TB_TABLE_SVH
`define CTL_TB_TABLE_SVH

// Columns: opcode, fix_b7, b7, cond, len, we_cnt, exp_reg, exp_add, exp_abh, idx_cyc and exp_idx
typedef struct packed {
    logic [7:0]           opcode;
    logic                 fix_b7;         // Operand bit 7 forced to b7
    logic                 b7;
    logic                 cond;           // Branch condition during the instruction
    logic [3:0]           len;            // Cycles from sync to sync
    logic [1:0]           we_cnt;         // Cycles with we high
    cpu_ctl_pkg::reg_op_t exp_reg;        // reg_op at the following sync
    logic [2:0]           exp_add;        // alu_op.add at the following sync
    logic [6:0]           exp_abh;        // ab_op.iph_abh in COND, BRA only
    logic [1:0]           idx_cyc;        // Cycle of ZERO or ABS1, 0 for none
    logic [3:0]           exp_idx;        // Index source in that cycle
} test_entry_t;

// Register writes seen at the sync that ends an instruction
localparam logic [6:0] W_A_Z = {1'b1, cpu_ctl_pkg::DST_A, cpu_ctl_pkg::REG_Z};
localparam logic [6:0] W_X_Z = {1'b1, cpu_ctl_pkg::DST_X, cpu_ctl_pkg::REG_Z};
localparam logic [6:0] W_Y_Z = {1'b1, cpu_ctl_pkg::DST_Y, cpu_ctl_pkg::REG_Z};
localparam logic [6:0] W_X_X = {1'b1, cpu_ctl_pkg::DST_X, cpu_ctl_pkg::REG_X};

localparam logic [2:0] A_ADD = cpu_ctl_pkg::ALU_ADD;
localparam logic [2:0] A_INC = cpu_ctl_pkg::ALU_INC;
localparam logic [2:0] A_DEC = cpu_ctl_pkg::ALU_DEC;

localparam logic [6:0] BR_BACK = 7'b011_0111;    // FF high-byte offset
localparam logic [6:0] BR_FWD  = 7'b011_0110;    // Forward or not taken
localparam logic [6:0] BR_NONE = 7'b000_0000;    // Not checked

// Index read, ZERO is cycle 2 and ABS1 is cycle 3
localparam logic [5:0] IX_NONE = {2'd0, cpu_ctl_pkg::REG_Z};
localparam logic [5:0] ZP_Z    = {2'd2, cpu_ctl_pkg::REG_Z};
localparam logic [5:0] ZP_X    = {2'd2, cpu_ctl_pkg::REG_X};
localparam logic [5:0] ZP_Y    = {2'd2, cpu_ctl_pkg::REG_Y};
localparam logic [5:0] ABS_Z   = {2'd3, cpu_ctl_pkg::REG_Z};
localparam logic [5:0] ABS_X   = {2'd3, cpu_ctl_pkg::REG_X};
localparam logic [5:0] ABS_Y   = {2'd3, cpu_ctl_pkg::REG_Y};

localparam logic [7:0] OP_NOP = 8'hEA;           // Not decoded here
localparam logic [7:0] OP_BRK = 8'h00;           // Dropped, acts as no-op

localparam int NUM_TESTS = 24;

test_entry_t tests [NUM_TESTS] = '{
    {cpu_ctl_pkg::OP_LDA_IMM,  1'b0, 1'b0, 1'b0, 4'd2, 2'd0, W_A_Z, A_ADD, BR_NONE, IX_NONE},
    {cpu_ctl_pkg::OP_LDX_IMM,  1'b0, 1'b0, 1'b0, 4'd2, 2'd0, W_X_Z, A_ADD, BR_NONE, IX_NONE},
    {cpu_ctl_pkg::OP_LDY_IMM,  1'b0, 1'b0, 1'b0, 4'd2, 2'd0, W_Y_Z, A_ADD, BR_NONE, IX_NONE},
    {cpu_ctl_pkg::OP_DEX,      1'b0, 1'b0, 1'b0, 4'd1, 2'd0, W_X_X, A_DEC, BR_NONE, IX_NONE},
    {cpu_ctl_pkg::OP_INX,      1'b0, 1'b0, 1'b0, 4'd1, 2'd0, W_X_X, A_INC, BR_NONE, IX_NONE},
    {cpu_ctl_pkg::OP_LDA_ZP,   1'b0, 1'b0, 1'b0, 4'd3, 2'd0, W_A_Z, A_ADD, BR_NONE, ZP_Z},
    {cpu_ctl_pkg::OP_PHA,      1'b0, 1'b0, 1'b0, 4'd3, 2'd1, W_A_Z, A_ADD, BR_NONE, IX_NONE},
    {cpu_ctl_pkg::OP_LDA_ZPX,  1'b0, 1'b0, 1'b0, 4'd3, 2'd0, W_A_Z, A_ADD, BR_NONE, ZP_X},
    {cpu_ctl_pkg::OP_LDX_ZPY,  1'b0, 1'b0, 1'b0, 4'd3, 2'd0, W_X_Z, A_ADD, BR_NONE, ZP_Y},
    {cpu_ctl_pkg::OP_JMP_ABS,  1'b0, 1'b0, 1'b0, 4'd3, 2'd0, W_X_Z, A_ADD, BR_NONE, ABS_Z},
    {cpu_ctl_pkg::OP_LDA_ABS,  1'b0, 1'b0, 1'b0, 4'd4, 2'd0, W_A_Z, A_ADD, BR_NONE, ABS_Z},
    {cpu_ctl_pkg::OP_LDA_ABSX, 1'b0, 1'b0, 1'b0, 4'd4, 2'd0, W_A_Z, A_ADD, BR_NONE, ABS_X},
    {cpu_ctl_pkg::OP_LDA_ABSY, 1'b0, 1'b0, 1'b0, 4'd4, 2'd0, W_A_Z, A_ADD, BR_NONE, ABS_Y},
    {cpu_ctl_pkg::OP_INX,      1'b0, 1'b0, 1'b0, 4'd1, 2'd0, W_X_X, A_INC, BR_NONE, IX_NONE},
    {cpu_ctl_pkg::OP_BRA,      1'b1, 1'b1, 1'b1, 4'd2, 2'd0, W_X_X, A_INC, BR_BACK, IX_NONE},
    {cpu_ctl_pkg::OP_BRA,      1'b1, 1'b0, 1'b1, 4'd2, 2'd0, W_X_X, A_INC, BR_FWD,  IX_NONE},
    {cpu_ctl_pkg::OP_BRA,      1'b1, 1'b1, 1'b0, 4'd2, 2'd0, W_X_X, A_INC, BR_FWD,  IX_NONE},
    {cpu_ctl_pkg::OP_PLA,      1'b0, 1'b0, 1'b0, 4'd3, 2'd0, W_A_Z, A_ADD, BR_NONE, IX_NONE},
    {OP_NOP,                   1'b0, 1'b0, 1'b0, 4'd1, 2'd0, W_A_Z, A_ADD, BR_NONE, IX_NONE},
    {cpu_ctl_pkg::OP_DEX,      1'b0, 1'b0, 1'b0, 4'd1, 2'd0, W_X_X, A_DEC, BR_NONE, IX_NONE},
    {cpu_ctl_pkg::OP_PHA,      1'b0, 1'b0, 1'b0, 4'd3, 2'd1, W_X_X, A_DEC, BR_NONE, IX_NONE},
    {OP_BRK,                   1'b0, 1'b0, 1'b0, 4'd1, 2'd0, W_X_X, A_DEC, BR_NONE, IX_NONE},
    {cpu_ctl_pkg::OP_BRA,      1'b1, 1'b0, 1'b0, 4'd2, 2'd0, W_X_X, A_DEC, BR_FWD,  IX_NONE},
    {cpu_ctl_pkg::OP_LDY_IMM,  1'b0, 1'b0, 1'b0, 4'd2, 2'd0, W_Y_Z, A_ADD, BR_NONE, IX_NONE}
};

`endif

//--- verif/ctl_tb.sv
// Testbench for the 65C02 control sequencer, runs an instruction table through ctl_top
`default_nettype none

module ctl_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_LEN      = 8;      // Beyond this the FSM is stuck
    localparam int MARGIN       = 20;     // Spare cycles for the watchdog

    localparam logic [3:0] BRANCH_MODE = cpu_ctl_pkg::AB_BRANCH;   // Mode seen in COND

    logic                 clk;
    logic                 reset;
    logic [7:0]           db;
    logic                 cond;
    logic                 sync;
    logic                 we;
    cpu_ctl_pkg::reg_op_t reg_op;
    cpu_ctl_pkg::alu_op_t alu_op;
    cpu_ctl_pkg::ab_op_t  ab_op;

    logic [31:0]          lcg_state;      // Operand generator state

    `include "ctl_tb_table.svh"

    ctl_top dut (
        .clk    (clk),
        .reset  (reset),
        .db     (db),
        .cond   (cond),
        .sync   (sync),
        .we     (we),
        .reg_op (reg_op),
        .alu_op (alu_op),
        .ab_op  (ab_op)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Whole run in cycles, reset and table plus slack
    function automatic int watchdog_cycles();
        int total;
        int i;
        total = RESET_CYCLES + 2 + MARGIN;
        for (i = 0; i < NUM_TESTS; i++) begin
            total += tests[i].len;
        end
        return total;
    endfunction

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic fail_plain(input string why);
        $display("%s", why);
        abort_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    // Random low bits, bit 7 pinned where the row asks
    task automatic next_operand(input test_entry_t e, output logic [7:0] operand);
        lcg_state = lcg_next(lcg_state);
        operand   = lcg_state[23:16];
        if (e.fix_b7) begin
            operand[7] = e.b7;
        end
    endtask

    initial begin : watchdog
        #(watchdog_cycles() * CLK_PERIOD);
        fail_plain("Watchdog expired: the sequencer hung and the test did not finish");
    end

    initial begin : stimulus
        test_entry_t e;
        logic [7:0]  operand;
        logic [7:0]  next_op;
        int          cycles;
        int          we_cnt;
        int          i;

        clk       = 1'b0;
        reset     = 1'b1;
        db        = 8'h00;
        cond      = 1'b0;
        lcg_state = 32'd23;

        for (i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_value("we", we, 1'b0);            // Held low in reset
        end
        @(posedge clk);
        reset <= 1'b0;
        db    <= tests[0].opcode;
        @(negedge clk);
        check_value("sync", sync, 1'b0);            // INIT cycle
        check_value("we", we, 1'b0);
        @(negedge clk);
        check_value("sync", sync, 1'b1);
        check_value("reg_op", reg_op, {1'b0, cpu_ctl_pkg::DST_X, cpu_ctl_pkg::REG_Z});

        for (i = 0; i < NUM_TESTS; i++) begin
            e       = tests[i];
            next_op = (i + 1 < NUM_TESTS) ? tests[i + 1].opcode : OP_NOP;
            next_operand(e, operand);
            cycles  = 1;                            // The sync cycle itself
            we_cnt  = we ? 1 : 0;
            @(posedge clk);
            cond <= e.cond;
            db   <= (e.len > 1) ? operand : next_op;   // One-cycle ops fetch again at once
            @(negedge clk);
            while (!sync) begin
                cycles++;
                if (we) begin
                    we_cnt++;
                end
                if (cycles > MAX_LEN) begin
                    fail_plain("Sequencer did not return to sync within the longest instruction");
                end
                if (cycles == 2 && e.opcode == cpu_ctl_pkg::OP_BRA) begin
                    check_value("ab_op.iph_abh", ab_op.iph_abh, e.exp_abh);   // COND cycle
                    check_value("ab_op.abl_sel", ab_op.abl_sel, BRANCH_MODE[1:0]);
                    check_value("ab_op.abl_ci", ab_op.abl_ci, BRANCH_MODE[2]);
                end
                if (e.idx_cyc != 2'd0 && cycles == e.idx_cyc) begin
                    check_value("reg_op.src", reg_op.src, e.exp_idx);   // ZERO or ABS1 index
                end
                @(posedge clk);
                db <= next_op;
                @(negedge clk);
            end
            check_value("instruction length", cycles, e.len);
            check_value("we cycles", we_cnt, e.we_cnt);
            check_value("reg_op", reg_op, e.exp_reg);
            check_value("alu_op.add", alu_op.add, e.exp_add);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/ctl_top.sv
// Top level of the 65C02 control sequencer
`default_nettype none

module ctl_top (
    input  wire                  clk,
    input  wire                  reset,
    input  wire  [7:0]           db,      // Opcode or operand
    input  wire                  cond,    // Branch condition
    output logic                 sync,
    output logic                 we,
    output cpu_ctl_pkg::reg_op_t reg_op,
    output cpu_ctl_pkg::alu_op_t alu_op,
    output cpu_ctl_pkg::ab_op_t  ab_op
);

    cpu_ctl_pkg::ctl_state_t state;
    cpu_ctl_pkg::insn_ctl_t  insn;
    cpu_ctl_pkg::ab_mode_t   mode;

    opcode_decode u_decode (
        .clk   (clk),
        .reset (reset),
        .sync  (sync),
        .db    (db),
        .insn  (insn)
    );

    ctl_fsm u_fsm (
        .clk   (clk),
        .reset (reset),
        .db    (db),
        .insn  (insn),
        .state (state),
        .sync  (sync)
    );

    ctl_microcode u_microcode (
        .clk    (clk),
        .reset  (reset),
        .state  (state),
        .insn   (insn),
        .reg_op (reg_op),
        .alu_op (alu_op),
        .we     (we),
        .mode   (mode)
    );

    ab_mode_map u_ab_map (
        .mode  (mode),
        .cond  (cond),
        .db    (db),
        .ab_op (ab_op)
    );

endmodule

`default_nettype wire

//--- hdl/ab_mode_map.sv
// Expands the four-bit address mode into the address datapath control word
`default_nettype none

module ab_mode_map (
    input  cpu_ctl_pkg::ab_mode_t mode,
    input  wire                   cond,
    input  wire  [7:0]            db,
    output cpu_ctl_pkg::ab_op_t   ab_op
);

    logic back;                               // Taken backward branch

    assign back = cond & db[7];

    always_comb begin
        ab_op.abl_sel = mode[1:0];            // Straight into ABL mux
        ab_op.abl_ci  = mode[2];              // ABL carry in
        case (mode)
            cpu_ctl_pkg::AB_KEEP: begin
                ab_op.iph_abh = 7'b001_0110;  // AB + 0
                ab_op.abl_src = 2'b11;
            end
            cpu_ctl_pkg::AB_PC: begin
                ab_op.iph_abh = 7'b000_1010;
                ab_op.abl_src = 2'b10;
            end
            cpu_ctl_pkg::AB_ABS: begin
                ab_op.iph_abh = 7'b111_1110;  // {DB, AHL + reg}, PC takes AB + 1
                ab_op.abl_src = 2'b01;
            end
            cpu_ctl_pkg::AB_ZP: begin
                ab_op.iph_abh = 7'b111_0000;  // {00, DB + reg}
                ab_op.abl_src = 2'b01;
            end
            cpu_ctl_pkg::AB_INC: begin
                ab_op.iph_abh = 7'b011_0110;
                ab_op.abl_src = 2'b11;
            end
            cpu_ctl_pkg::AB_SP_INC: begin
                ab_op.iph_abh = 7'b011_0001;  // Page one
                ab_op.abl_src = 2'b00;
            end
            cpu_ctl_pkg::AB_BRANCH: begin
                // FF high offset only for a taken backward branch
                ab_op.iph_abh = back ? 7'b011_0111 : 7'b011_0110;
                ab_op.abl_src = 2'b11;
            end
            cpu_ctl_pkg::AB_SP_KEEP_PC: begin
                ab_op.iph_abh = 7'b010_0001;
                ab_op.abl_src = 2'b00;
            end
            default: begin
                ab_op.iph_abh = 7'b001_0110;  // Same as keep
                ab_op.abl_src = 2'b11;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- sequencer/ctl_microcode.sv
// Per-state register, ALU, write enable and address mode outputs
`default_nettype none

module ctl_microcode (
    input  wire                     clk,
    input  wire                     reset,
    input  cpu_ctl_pkg::ctl_state_t state,
    input  cpu_ctl_pkg::insn_ctl_t  insn,
    output cpu_ctl_pkg::reg_op_t    reg_op,
    output cpu_ctl_pkg::alu_op_t    alu_op,
    output logic                    we,
    output cpu_ctl_pkg::ab_mode_t   mode
);

    logic [3:0] index_src;                      // Offset register for ZERO and ABS1

    always_comb begin
        if (insn.add_x) begin
            index_src = cpu_ctl_pkg::REG_X;
        end else if (insn.add_y) begin
            index_src = cpu_ctl_pkg::REG_Y;
        end else begin
            index_src = cpu_ctl_pkg::REG_Z;     // No index, add zero
        end
    end

    always_comb begin
        reg_op = '{write: 1'b0, dst: cpu_ctl_pkg::DST_X, src: cpu_ctl_pkg::REG_Z};
        case (state)
            cpu_ctl_pkg::SYNC: reg_op = '{write: insn.ld, dst: insn.dst, src: insn.src};
            cpu_ctl_pkg::DATA: begin
                reg_op.dst = insn.dst;
                reg_op.src = insn.st ? cpu_ctl_pkg::REG_A : insn.src;   // PHA drives A
            end
            cpu_ctl_pkg::ZERO,
            cpu_ctl_pkg::ABS1: reg_op.src = index_src;
            cpu_ctl_pkg::PUSH,
            cpu_ctl_pkg::PULL: reg_op = '{write: 1'b1, dst: cpu_ctl_pkg::DST_S,
                                          src: cpu_ctl_pkg::REG_S};
            default: ;
        endcase
    end

    always_comb begin
        alu_op = '0;                            // OR with zero
        case (state)
            cpu_ctl_pkg::SYNC: begin
                {alu_op.shift, alu_op.add, alu_op.carry} = insn.alu;
            end
            cpu_ctl_pkg::IMM0: alu_op.ldm = 1'b1;
            cpu_ctl_pkg::DATA: begin
                if (insn.st) begin
                    alu_op.add = cpu_ctl_pkg::ALU_INC;   // Pass source to bus
                end else begin
                    alu_op.ldm = 1'b1;
                end
            end
            cpu_ctl_pkg::PUSH: alu_op.add = cpu_ctl_pkg::ALU_DEC;   // S - 1
            cpu_ctl_pkg::PULL: begin
                alu_op.add   = cpu_ctl_pkg::ALU_INC;                // S + 1
                alu_op.carry = 2'b01;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (state)
            cpu_ctl_pkg::INIT: mode = cpu_ctl_pkg::AB_KEEP;
            cpu_ctl_pkg::SYNC,
            cpu_ctl_pkg::IMM0,
            cpu_ctl_pkg::ABS0: mode = cpu_ctl_pkg::AB_INC;
            cpu_ctl_pkg::ABS1: mode = cpu_ctl_pkg::AB_ABS;
            cpu_ctl_pkg::ZERO: mode = cpu_ctl_pkg::AB_ZP;
            cpu_ctl_pkg::DATA: mode = cpu_ctl_pkg::AB_PC;
            cpu_ctl_pkg::PUSH: mode = cpu_ctl_pkg::AB_SP_KEEP_PC;
            cpu_ctl_pkg::PULL: mode = cpu_ctl_pkg::AB_SP_INC;
            cpu_ctl_pkg::COND: mode = cpu_ctl_pkg::AB_BRANCH;
            default:           mode = cpu_ctl_pkg::AB_KEEP;
        endcase
    end

    // Write strobe lands in the DATA cycle that follows PUSH
    always_ff @(posedge clk) begin
        if (reset) begin
            we <= 1'b0;
        end else begin
            we <= (state == cpu_ctl_pkg::PUSH);
        end
    end

endmodule

`default_nettype wire

//--- sequencer/ctl_fsm.sv
// Instruction sequencer FSM, one state per clock
`default_nettype none

module ctl_fsm (
    input  wire                     clk,
    input  wire                     reset,
    input  wire  [7:0]              db,
    input  cpu_ctl_pkg::insn_ctl_t  insn,
    output cpu_ctl_pkg::ctl_state_t state,
    output logic                    sync
);

    cpu_ctl_pkg::ctl_state_t state_next;

    assign sync = (state == cpu_ctl_pkg::SYNC);

    always_comb begin
        state_next = state;
        case (state)
            cpu_ctl_pkg::INIT: state_next = cpu_ctl_pkg::SYNC;
            cpu_ctl_pkg::SYNC: begin
                // Dispatch on opcode, anything else is a one-cycle no-op
                case (db)
                    cpu_ctl_pkg::OP_BRA:      state_next = cpu_ctl_pkg::COND;
                    cpu_ctl_pkg::OP_JMP_ABS:  state_next = cpu_ctl_pkg::ABS0;
                    cpu_ctl_pkg::OP_LDA_ZP,
                    cpu_ctl_pkg::OP_LDA_ZPX,
                    cpu_ctl_pkg::OP_LDX_ZPY:  state_next = cpu_ctl_pkg::ZERO;
                    cpu_ctl_pkg::OP_LDA_ABS,
                    cpu_ctl_pkg::OP_LDA_ABSX,
                    cpu_ctl_pkg::OP_LDA_ABSY: state_next = cpu_ctl_pkg::ABS0;
                    cpu_ctl_pkg::OP_LDA_IMM,
                    cpu_ctl_pkg::OP_LDX_IMM,
                    cpu_ctl_pkg::OP_LDY_IMM:  state_next = cpu_ctl_pkg::IMM0;
                    cpu_ctl_pkg::OP_PHA:      state_next = cpu_ctl_pkg::PUSH;
                    cpu_ctl_pkg::OP_PLA:      state_next = cpu_ctl_pkg::PULL;
                    default:                  state_next = cpu_ctl_pkg::SYNC;
                endcase
            end
            cpu_ctl_pkg::IMM0: state_next = cpu_ctl_pkg::SYNC;
            cpu_ctl_pkg::ZERO: state_next = cpu_ctl_pkg::DATA;
            cpu_ctl_pkg::ABS0: state_next = cpu_ctl_pkg::ABS1;
            cpu_ctl_pkg::ABS1: begin
                if (insn.jmp) begin
                    state_next = cpu_ctl_pkg::SYNC;     // Jump target now on AB
                end else begin
                    state_next = cpu_ctl_pkg::DATA;
                end
            end
            cpu_ctl_pkg::DATA: state_next = cpu_ctl_pkg::SYNC;
            cpu_ctl_pkg::PUSH: state_next = cpu_ctl_pkg::DATA;
            cpu_ctl_pkg::PULL: state_next = cpu_ctl_pkg::DATA;
            cpu_ctl_pkg::COND: state_next = cpu_ctl_pkg::SYNC;
            default:           state_next = cpu_ctl_pkg::INIT;    // Recover from bad code
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cpu_ctl_pkg::INIT;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/opcode_decode.sv
// Opcode decoder that latches the per-instruction control fields at sync
`default_nettype none

module opcode_decode (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    sync,
    input  wire  [7:0]             db,
    output cpu_ctl_pkg::insn_ctl_t insn
);

    cpu_ctl_pkg::insn_ctl_t insn_next;

    always_comb begin
        insn_next       = insn;           // ld, dst, src, alu hold by default
        insn_next.jmp   = 1'b0;
        insn_next.add_x = 1'b0;
        insn_next.add_y = 1'b0;
        insn_next.st    = 1'b0;

        // Index register selection for ZERO and ABS1
        case (db)
            cpu_ctl_pkg::OP_LDA_ZPX,
            cpu_ctl_pkg::OP_LDA_ABSX: insn_next.add_x = 1'b1;
            cpu_ctl_pkg::OP_LDX_ZPY,
            cpu_ctl_pkg::OP_LDA_ABSY: insn_next.add_y = 1'b1;
            cpu_ctl_pkg::OP_JMP_ABS:  insn_next.jmp = 1'b1;
            cpu_ctl_pkg::OP_PHA:      insn_next.st = 1'b1;
            default: ;
        endcase

        // Register write and ALU function for the end of the instruction
        case (db)
            cpu_ctl_pkg::OP_LDA_IMM, cpu_ctl_pkg::OP_LDA_ZP, cpu_ctl_pkg::OP_LDA_ZPX,
            cpu_ctl_pkg::OP_LDA_ABS, cpu_ctl_pkg::OP_LDA_ABSX, cpu_ctl_pkg::OP_LDA_ABSY,
            cpu_ctl_pkg::OP_PLA: begin
                insn_next.ld  = 1'b1;
                insn_next.dst = cpu_ctl_pkg::DST_A;
                insn_next.src = cpu_ctl_pkg::REG_Z;      // A = 0 + M
                insn_next.alu = {2'b00, cpu_ctl_pkg::ALU_ADD, 2'b00};
            end
            cpu_ctl_pkg::OP_LDX_IMM, cpu_ctl_pkg::OP_LDX_ZPY: begin
                insn_next.ld  = 1'b1;
                insn_next.dst = cpu_ctl_pkg::DST_X;
                insn_next.src = cpu_ctl_pkg::REG_Z;
                insn_next.alu = {2'b00, cpu_ctl_pkg::ALU_ADD, 2'b00};
            end
            cpu_ctl_pkg::OP_LDY_IMM: begin
                insn_next.ld  = 1'b1;
                insn_next.dst = cpu_ctl_pkg::DST_Y;
                insn_next.src = cpu_ctl_pkg::REG_Z;
                insn_next.alu = {2'b00, cpu_ctl_pkg::ALU_ADD, 2'b00};
            end
            cpu_ctl_pkg::OP_DEX: begin
                insn_next.ld  = 1'b1;
                insn_next.dst = cpu_ctl_pkg::DST_X;
                insn_next.src = cpu_ctl_pkg::REG_X;
                insn_next.alu = {2'b00, cpu_ctl_pkg::ALU_DEC, 2'b00};   // X - 1
            end
            cpu_ctl_pkg::OP_INX: begin
                insn_next.ld  = 1'b1;
                insn_next.dst = cpu_ctl_pkg::DST_X;
                insn_next.src = cpu_ctl_pkg::REG_X;
                insn_next.alu = {2'b00, cpu_ctl_pkg::ALU_INC, 2'b01};   // X + 1, carry in set
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            insn     <= '0;
            insn.src <= cpu_ctl_pkg::REG_Z;     // First SYNC writes nothing
        end else if (sync) begin
            insn <= insn_next;                  // Held until next SYNC
        end
    end

endmodule

`default_nettype wire

//--- common/cpu_ctl_pkg.sv
// Shared types and constants for the 65C02 control sequencer
`default_nettype none

package cpu_ctl_pkg;

    typedef enum logic [3:0] {
        INIT = 4'd0,                      // After reset, one cycle
        SYNC = 4'd1,                      // Opcode fetch and dispatch
        IMM0 = 4'd2,                      // Immediate operand
        ZERO = 4'd3,                      // Zero page address
        ABS0 = 4'd4,                      // Absolute address low byte
        ABS1 = 4'd5,                      // Absolute address high byte
        DATA = 4'd6,                      // Memory data cycle
        PUSH = 4'd7,                      // Stack write setup
        PULL = 4'd8,                      // Stack read setup
        COND = 4'd9                       // Branch target
    } ctl_state_t;

    // Address datapath modes, bits 1:0 feed the ABL mux and bit 2 its carry
    typedef enum logic [3:0] {
        AB_KEEP       = 4'd0,             // AB unchanged
        AB_PC         = 4'd1,             // Back to PC
        AB_ABS        = 4'd2,             // {DB, AHL + index}
        AB_ZP         = 4'd3,             // {00, DB + index}
        AB_INC        = 4'd4,             // AB + 1
        AB_SP_INC     = 4'd5,             // {01, SP + 1}
        AB_BRANCH     = 4'd7,             // AB + offset + 1
        AB_SP_KEEP_PC = 4'd11             // {01, SP}, PC holds AB
    } ab_mode_t;

    typedef struct packed {
        logic       write;                // Register file write enable
        logic [1:0] dst;                  // Destination register
        logic [3:0] src;                  // Source register
    } reg_op_t;

    typedef struct packed {
        logic       ldm;                  // Load from memory
        logic       bcd;                  // Decimal mode
        logic [1:0] shift;                // 10 left, 11 right
        logic [2:0] add;                  // Adder function
        logic [1:0] carry;                // 01 set, 10 rotate, 11 ADC
    } alu_op_t;

    typedef struct packed {
        logic [6:0] iph_abh;              // PC hold, AHL hold and ABH controls
        logic [1:0] abl_sel;
        logic [1:0] abl_src;
        logic       abl_ci;
    } ab_op_t;

    // Instruction fields latched at the end of SYNC
    typedef struct packed {
        logic       jmp;                  // ABS1 ends the instruction
        logic       add_x;                // Index with X
        logic       add_y;                // Index with Y
        logic       ld;                   // Register write at next SYNC
        logic       st;                   // Store to memory in DATA
        logic [1:0] dst;
        logic [3:0] src;
        logic [6:0] alu;                  // shift, add, carry
    } insn_ctl_t;

    localparam logic [7:0] OP_LDA_IMM  = 8'hA9;
    localparam logic [7:0] OP_LDX_IMM  = 8'hA2;
    localparam logic [7:0] OP_LDY_IMM  = 8'hA0;
    localparam logic [7:0] OP_LDA_ZP   = 8'hA5;
    localparam logic [7:0] OP_LDA_ZPX  = 8'hB5;
    localparam logic [7:0] OP_LDX_ZPY  = 8'hB6;
    localparam logic [7:0] OP_LDA_ABS  = 8'hAD;
    localparam logic [7:0] OP_LDA_ABSX = 8'hBD;
    localparam logic [7:0] OP_LDA_ABSY = 8'hB9;
    localparam logic [7:0] OP_DEX      = 8'hCA;
    localparam logic [7:0] OP_INX      = 8'hE8;
    localparam logic [7:0] OP_PHA      = 8'h48;
    localparam logic [7:0] OP_PLA      = 8'h68;
    localparam logic [7:0] OP_JMP_ABS  = 8'h4C;
    localparam logic [7:0] OP_BRA      = 8'h80;

    localparam logic [3:0] REG_X = 4'd0;  // Source codes
    localparam logic [3:0] REG_Y = 4'd1;
    localparam logic [3:0] REG_A = 4'd2;
    localparam logic [3:0] REG_S = 4'd3;  // Stack pointer
    localparam logic [3:0] REG_Z = 4'd7;  // Reads as zero

    localparam logic [1:0] DST_X = 2'd0;  // Destination codes
    localparam logic [1:0] DST_Y = 2'd1;
    localparam logic [1:0] DST_A = 2'd2;
    localparam logic [1:0] DST_S = 2'd3;

    localparam logic [2:0] ALU_ADD = 3'b011;
    localparam logic [2:0] ALU_INC = 3'b100;
    localparam logic [2:0] ALU_DEC = 3'b101;

endpackage

`default_nettype wire
